// ==== compile.f ====
+incdir+rtl
rtl/bubbleTimingPkg.sv
rtl/timingBus.sv
rtl/controlSynchronizer.sv
rtl/rotationSequencer.sv
rtl/phaseDecoder.sv
rtl/positionTracker.sv
rtl/bubbleTimingTop.sv
verification/bubbleTiming_assert.sv
verification/bubbleTimingTb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = bubbleTimingTb
FILELIST  = compile.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_TEXT = All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verification/bubbleTimingTb.sv ====
module bubbleTimingTb import bubbleTimingPkg::*;
();

    typedef struct
    {
        string      name;
        logic [3:0] requests;    // {select, shift, replicator, bootloop}
        int         hold;        // Cycles with shiftRequest high
        int         changes;     // positionChange pulses
        int         strobes;     // dataOutStrobe pulses
        int         latches;     // positionLatch pulses
        int         coilStarts;  // coilRun rising edges
        int         position;    // positionCount after wind-down
        int         latched;     // latchedPosition after wind-down
    } testRow_t;

    logic       clock12MHz        = 1'b0;
    logic       reset             = 1'b1;
    logic       moduleSelect      = 1'b0;
    logic       shiftRequest      = 1'b0;
    logic       replicatorRequest = 1'b0;
    logic       bootloopRequest   = 1'b0;

    logic       coilRun;
    coilPhase_t coilPhase;
    logic       positionChange;
    logic       dataOutNotice;
    logic       dataOutStrobe;
    logic       positionLatch;
    logic       pageSelect;
    position_t  positionCount;
    position_t  latchedPosition;

    testRow_t   rows[$];
    int         testErrors  = 0;
    int         passedTests = 0;
    int         failedTests = 0;

    // Running pulse totals, never cleared
    int         changeTotal = 0;
    int         strobeTotal = 0;
    int         latchTotal  = 0;
    int         coilTotal   = 0;
    logic       changeLast  = 1'b0;
    logic       strobeLast  = 1'b0;
    logic       latchLast   = 1'b0;
    logic       coilLast    = 1'b0;

    // Running high-cycle totals
    int         noticeCycles = 0;
    int         plusXCycles  = 0;

    always #20 clock12MHz = ~clock12MHz;   // 40 unit period

    bubbleTimingTop UUT
    (
        .clock12MHz        (clock12MHz),
        .reset             (reset),
        .moduleSelect      (moduleSelect),
        .shiftRequest      (shiftRequest),
        .replicatorRequest (replicatorRequest),
        .bootloopRequest   (bootloopRequest),
        .coilRun           (coilRun),
        .coilPhase         (coilPhase),
        .positionChange    (positionChange),
        .dataOutNotice     (dataOutNotice),
        .dataOutStrobe     (dataOutStrobe),
        .positionLatch     (positionLatch),
        .pageSelect        (pageSelect),
        .positionCount     (positionCount),
        .latchedPosition   (latchedPosition)
    );

    // Rising edge counter, values read before the clock updates them
    always @(posedge clock12MHz)
    begin
        if (positionChange && !changeLast)
            changeTotal++;
        if (dataOutStrobe && !strobeLast)
            strobeTotal++;
        if (positionLatch && !latchLast)
            latchTotal++;
        if (coilRun && !coilLast)
            coilTotal++;
        if (dataOutNotice)
            noticeCycles++;
        if (coilPhase[0])
            plusXCycles++;   // +X coil on
        changeLast = positionChange;
        strobeLast = dataOutStrobe;
        latchLast  = positionLatch;
        coilLast   = coilRun;
    end

    task automatic addRow(input string name, input logic [3:0] requests, input int hold,
                          input int changes, input int strobes, input int latches,
                          input int coilStarts, input int position, input int latched);
        testRow_t row;
        row.name       = name;
        row.requests   = requests;
        row.hold       = hold;
        row.changes    = changes;
        row.strobes    = strobes;
        row.latches    = latches;
        row.coilStarts = coilStarts;
        row.position   = position;
        row.latched    = latched;
        rows.push_back(row);
    endtask

    task automatic compareValue(input string testName, input string label,
                                input int expected, input int actual);
        assert (actual == expected)
        else
        begin
            $display("Mismatch %s %s: expected %0d, actual %0d",
                     testName, label, expected, actual);
            testErrors++;
        end
    endtask

    task automatic runRow(input testRow_t row);
        int changeStart;
        int strobeStart;
        int latchStart;
        int coilStart;
        int noticeStart;
        int plusXStart;
        int waited;
        int gap;
        @(negedge clock12MHz);
        changeStart = changeTotal;
        strobeStart = strobeTotal;
        latchStart  = latchTotal;
        coilStart   = coilTotal;
        noticeStart = noticeCycles;
        plusXStart  = plusXCycles;
        {moduleSelect, shiftRequest, replicatorRequest, bootloopRequest} = row.requests;
        repeat (row.hold) @(negedge clock12MHz);
        shiftRequest = 1'b0;   // Other requests stay up through the wind-down
        waited = 0;
        while (waited < 200 || coilRun)
        begin
            @(negedge clock12MHz);
            waited++;
        end
        testErrors = 0;
        compareValue(row.name, "positionChange pulses", row.changes, changeTotal - changeStart);
        compareValue(row.name, "dataOutStrobe pulses", row.strobes, strobeTotal - strobeStart);
        compareValue(row.name, "positionLatch pulses", row.latches, latchTotal - latchStart);
        compareValue(row.name, "coilRun starts", row.coilStarts, coilTotal - coilStart);
        compareValue(row.name, "positionCount", row.position, int'(positionCount));
        compareValue(row.name, "latchedPosition", row.latched, int'(latchedPosition));
        // Clamp window 56..93 is 38 counts, one per strobe
        compareValue(row.name, "dataOutNotice cycles", row.strobes * 38,
                     noticeCycles - noticeStart);
        // +X coil spans 73..109, once per position step
        compareValue(row.name, "+X coil cycles", row.changes * 37,
                     plusXCycles - plusXStart);
        compareValue(row.name, "pageSelect", int'(row.requests[3] & row.requests[0]),
                     int'(pageSelect));
        if (testErrors == 0)
        begin
            $display("%s: ok", row.name);
            passedTests++;
        end
        else
        begin
            $display("%s: %0d checks failed", row.name, testErrors);
            failedTests++;
        end
        {moduleSelect, shiftRequest, replicatorRequest, bootloopRequest} = 4'b0000;
        gap = 5 + int'($urandom % 26);   // Idle spacing, 5 to 30 cycles
        repeat (gap) @(negedge clock12MHz);
    endtask

    initial
    begin
        void'($urandom(32'h58d2cda8));
        // Hold = 3 sync + 18 to first coil + 120 per rotation, ends at count 21
        addRow("idleNoShift",      4'b1011,    100,    0,    0,    0, 0, 0, 0);
        addRow("idleNoSelect",     4'b0111,    300,    0,    0,    0, 0, 0, 0);
        addRow("oneRotation",      4'b1100,    141,    1,    1,    0, 1, 1, 0);
        addRow("threeRotations",   4'b1100,    381,    3,    3,    0, 1, 4, 0);
        addRow("stopInNegX",       4'b1100,     30,    0,    0,    0, 1, 4, 0);   // 45 jumps to 166
        addRow("stopLate",         4'b1100,    100,    1,    1,    0, 1, 5, 0);   // Finishes the turn
        addRow("replicatorPage",   4'b1111,    261,    2,    2,    3, 1, 7, 7);
        addRow("replicatorNoPage", 4'b1110,    141,    1,    1,    0, 1, 8, 7);
        addRow("wrapLongRun",      4'b1111, 246021, 2050, 2050, 2051, 1, 5, 5);   // 8 + 2050 mod 2053
        repeat (3) @(negedge clock12MHz);
        reset = 1'b0;
        foreach (rows[i])
            runRow(rows[i]);
        $display("%0d tests run, %0d passed, %0d failed", rows.size(), passedTests, failedTests);
        if (failedTests == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

    // Watchdog sized from the table
    initial
    begin
        int limitCycles;
        @(negedge reset);
        limitCycles = 0;
        foreach (rows[i])
            limitCycles += rows[i].hold + 400;
        repeat (limitCycles) @(posedge clock12MHz);
        $display("Run timed out after %0d cycles before all tests finished", limitCycles);
        $display("Some tests failed");
        $finish;
    end

endmodule

// ==== verification/bubbleTiming_assert.sv ====
module bubbleTimingAssert import bubbleTimingPkg::*;
(
    input logic       clock12MHz,
    input logic       reset,
    input logic       coilRun,
    input coilPhase_t coilPhase,
    input logic       dataOutNotice,
    input logic       dataOutStrobe,
    input logic       positionLatch,
    input logic       pageSelect
);

    // Strobe window sits inside the clamp window
    strobeInsideNotice: assert property (@(posedge clock12MHz) disable iff (reset)
        dataOutStrobe |-> dataOutNotice)
        else $error("dataOutStrobe high without dataOutNotice");

    // Latch only on the boot page
    latchNeedsPage: assert property (@(posedge clock12MHz) disable iff (reset)
        positionLatch |-> pageSelect)
        else $error("positionLatch high without pageSelect");

    // No coil drive with the field stopped
    coilsQuietWhenStopped: assert property (@(posedge clock12MHz) disable iff (reset)
        !coilRun |-> (coilPhase == 4'b0000))
        else $error("coilPhase active while coilRun is low");

    coilLowAfterReset: assert property (@(posedge clock12MHz)
        reset |=> !coilRun)
        else $error("coilRun high right after reset");

endmodule

bind bubbleTimingTop bubbleTimingAssert checks
(
    .clock12MHz    (clock12MHz),
    .reset         (reset),
    .coilRun       (coilRun),
    .coilPhase     (coilPhase),
    .dataOutNotice (dataOutNotice),
    .dataOutStrobe (dataOutStrobe),
    .positionLatch (positionLatch),
    .pageSelect    (pageSelect)
);

// ==== rtl/bubbleTimingTop.sv ====
module bubbleTimingTop import bubbleTimingPkg::*;
(
    input  logic       clock12MHz,
    input  logic       reset,

    // Controller requests, already active high
    input  logic       moduleSelect,
    input  logic       shiftRequest,
    input  logic       replicatorRequest,
    input  logic       bootloopRequest,

    // Field and sense timing
    output logic       coilRun,
    output coilPhase_t coilPhase,
    output logic       positionChange,
    output logic       dataOutNotice,
    output logic       dataOutStrobe,
    output logic       positionLatch,
    output logic       pageSelect,

    // Loop position
    output position_t  positionCount,
    output position_t  latchedPosition
);

    timingBus bus();

    controlSynchronizer synchronizer
    (
        .clock12MHz        (clock12MHz),
        .reset             (reset),
        .moduleSelect      (moduleSelect),
        .shiftRequest      (shiftRequest),
        .replicatorRequest (replicatorRequest),
        .bootloopRequest   (bootloopRequest),
        .bus               (bus.sync)
    );

    rotationSequencer sequencer
    (
        .clock12MHz (clock12MHz),
        .reset      (reset),
        .bus        (bus.seq)
    );

    phaseDecoder decoder
    (
        .bus            (bus.dec),
        .coilPhase      (coilPhase),
        .positionChange (positionChange),
        .positionLatch  (positionLatch),
        .dataOutNotice  (dataOutNotice),
        .dataOutStrobe  (dataOutStrobe)
    );

    positionTracker tracker
    (
        .clock12MHz      (clock12MHz),
        .reset           (reset),
        .positionChange  (positionChange),
        .positionLatch   (positionLatch),
        .positionCount   (positionCount),
        .latchedPosition (latchedPosition)
    );

    // Bus levels that leave the chip directly
    assign coilRun    = bus.coilRun;
    assign pageSelect = bus.pageSelect;

endmodule

// ==== rtl/positionTracker.sv ====
`include "bubbleTiming_macros.svh"

module positionTracker import bubbleTimingPkg::*;
(
    input  logic      clock12MHz,
    input  logic      reset,

    input  logic      positionChange,
    input  logic      positionLatch,

    output position_t positionCount,
    output position_t latchedPosition
);

    logic changeDelayed;
    logic latchDelayed;
    logic changeEdge;
    logic latchEdge;

    // Strobes last several counts, act on the first one only
    assign changeEdge = positionChange & ~changeDelayed;
    assign latchEdge  = positionLatch & ~latchDelayed;

    always_ff @(posedge clock12MHz)
    begin
        if (reset)
        begin
            changeDelayed   <= 1'b0;
            latchDelayed    <= 1'b0;
            positionCount   <= '0;
            latchedPosition <= '0;
        end
        else
        begin
            changeDelayed <= positionChange;
            latchDelayed  <= positionLatch;

            if (changeEdge)
            begin
                // Wrap at the end of the minor loop
                if (positionCount == `LOOP_POSITIONS - 12'd1)
                    positionCount <= '0;
                else
                    positionCount <= positionCount + 12'd1;
            end

            if (latchEdge)
                latchedPosition <= positionCount;   // Value before any step this cycle
        end
    end

endmodule

// ==== rtl/phaseDecoder.sv ====
`include "bubbleTiming_macros.svh"

module phaseDecoder import bubbleTimingPkg::*;
(
    timingBus.dec      bus,

    output coilPhase_t coilPhase,
    output logic       positionChange,
    output logic       positionLatch,
    output logic       dataOutNotice,
    output logic       dataOutStrobe
);

    coilPhase_t coilDecode;
    logic       fieldActive;
    logic       repWindow;
    logic       repPulse;

    // Vector walk around one rotation, [+Y -Y -X +X]
    always_comb
    begin
        case (bus.stateCount) inside
            [`COIL_START:`XNEG_END]: coilDecode = 4'b0010;   // -X
            [8'd46:8'd48]:           coilDecode = 4'b0110;   // -X into -Y
            [8'd49:8'd72]:           coilDecode = 4'b0100;   // -Y
            [8'd73:8'd79]:           coilDecode = 4'b0101;   // -Y into +X
            [8'd80:8'd105]:          coilDecode = 4'b0001;   // +X
            [8'd106:8'd109]:         coilDecode = 4'b1001;   // +X into +Y
            [8'd110:8'd137]:         coilDecode = 4'b1000;   // +Y
            [8'd138:`LOOP_TOP]:      coilDecode = 4'b1010;   // +Y into -X
            [8'd140:`COIL_END]:      coilDecode = 4'b0010;   // -X tail
            default:                 coilDecode = 4'b0000;
        endcase
    end

    // Coils only while the sequencer says the field runs
    assign coilPhase = bus.coilRun ? coilDecode : 4'b0000;

    // Bubble steps one position at the +Y/-X overlap
    assign positionChange = coilPhase[3] & coilPhase[1];

    // Sense amplifier, clamp released first then strobe
    assign dataOutNotice = inWindow(bus.stateCount, `CLAMP_START, `SENSE_END);
    assign dataOutStrobe = inWindow(bus.stateCount, `STROBE_START, `SENSE_END);

    // Rotating field, or a shift about to start it
    assign fieldActive = bus.coilRun | bus.shiftActive;

    // Two replicate slots, one early and one on the tail
    assign repWindow =
        inWindow(bus.stateCount, `REP_PULSE_A, `REP_PULSE_A + `REP_PULSE_LEN - 8'd1) ||
        inWindow(bus.stateCount, `REP_PULSE_B, `REP_PULSE_B + `REP_PULSE_LEN - 8'd1);

    assign repPulse = bus.replicatorActive & fieldActive & repWindow;

    // Latch only makes sense for the boot page
    assign positionLatch = repPulse & bus.pageSelect;

endmodule

// ==== rtl/rotationSequencer.sv ====
`include "bubbleTiming_macros.svh"

module rotationSequencer import bubbleTimingPkg::*;
(
    input  logic  clock12MHz,
    input  logic  reset,

    timingBus.seq bus
);

    stateCount_t stateCount;
    stateCount_t countNext;
    seqState_t   seqState;
    seqState_t   stateNext;
    logic        coilRun;

    // Field runs across the whole coil window
    assign coilRun = inWindow(stateCount, `COIL_START, `COIL_END);

    always_comb
    begin
        countNext = '0;
        if (bus.shiftActive)
        begin
            // One full rotation is LOOP_RETURN..LOOP_TOP
            if (stateCount == `LOOP_TOP)
                countNext = `LOOP_RETURN;
            else
                countNext = stateCount + 8'd1;
        end
        else if (seqState == seqIdle || !coilRun)
        begin
            countNext = '0;   // Nothing rotating, park the counter
        end
        else if (inWindow(stateCount, `COIL_START, `XNEG_END - 8'd1))
        begin
            countNext = stateCount + 8'd1;   // Still in -X, finish it
        end
        else if (stateCount == `XNEG_END)
        begin
            // Skip the rest of the rotation, go to the -X tail
            countNext = `STOP_JUMP;
        end
        else if (inWindow(stateCount, `XNEG_END + 8'd1, `COIL_END))
        begin
            countNext = stateCount + 8'd1;   // Complete the running rotation
        end
        else
        begin
            countNext = '0;
        end
    end

    // Mode of the count that is about to be loaded
    always_comb
    begin
        if (bus.shiftActive)
            stateNext = seqShift;
        else if (inWindow(countNext, `COIL_START, `COIL_END))
            stateNext = seqStop;
        else
            stateNext = seqIdle;
    end

    always_ff @(posedge clock12MHz)
    begin
        if (reset)
        begin
            stateCount <= '0;
            seqState   <= seqIdle;
        end
        else
        begin
            stateCount <= countNext;
            seqState   <= stateNext;
        end
    end

    assign bus.stateCount = stateCount;
    assign bus.coilRun    = coilRun;

endmodule

// ==== rtl/controlSynchronizer.sv ====
module controlSynchronizer
(
    input  logic   clock12MHz,
    input  logic   reset,

    input  logic   moduleSelect,
    input  logic   shiftRequest,
    input  logic   replicatorRequest,
    input  logic   bootloopRequest,

    timingBus.sync bus
);

    // Bit order {shift, replicator, page}
    logic [2:0] gatedRequest;
    logic [2:0] stageOne;
    logic [2:0] stageTwo;
    logic [2:0] stageThree;

    // Requests only count while the module is selected
    assign gatedRequest[2] = moduleSelect & shiftRequest;
    assign gatedRequest[1] = moduleSelect & replicatorRequest;
    assign gatedRequest[0] = moduleSelect & bootloopRequest;

    // Three stages, fixed three-cycle latency
    always_ff @(posedge clock12MHz)
    begin
        if (reset)
        begin
            stageOne   <= '0;
            stageTwo   <= '0;
            stageThree <= '0;
        end
        else
        begin
            stageOne   <= gatedRequest;
            stageTwo   <= stageOne;
            stageThree <= stageTwo;   // Sequencer landmarks assume this delay
        end
    end

    assign bus.shiftActive      = stageThree[2];
    assign bus.replicatorActive = stageThree[1];
    assign bus.pageSelect       = stageThree[0];

endmodule

// ==== rtl/timingBus.sv ====
interface timingBus import bubbleTimingPkg::*; ();

    // Synchronized controls
    logic        shiftActive;       // Shift request, gated by module select
    logic        replicatorActive;  // Replicator enable
    logic        pageSelect;        // Bootloop page select

    // Sequencer state
    stateCount_t stateCount;
    logic        coilRun;           // High while the field rotates

    // Synchronizer side
    modport sync
    (
        output shiftActive,
        output replicatorActive,
        output pageSelect
    );

    // Sequencer needs only the shift level
    modport seq
    (
        input  shiftActive,
        output stateCount,
        output coilRun
    );

    // Decoder watches everything
    modport dec
    (
        input  shiftActive,
        input  replicatorActive,
        input  pageSelect,
        input  stateCount,
        input  coilRun
    );

endinterface

// ==== rtl/bubbleTimingPkg.sv ====
`include "bubbleTiming_macros.svh"

package bubbleTimingPkg;

    // Rotation state count
    typedef logic [`STATE_WIDTH-1:0] stateCount_t;

    // Bubble position around the minor loop
    typedef logic [`POSITION_WIDTH-1:0] position_t;

    // Coil enables, bit order [+Y -Y -X +X], active high
    typedef logic [3:0] coilPhase_t;

    // Sequencer mode
    typedef enum logic [1:0]
    {
        seqIdle  = 2'd0,   // Field stopped, counter parked at 0
        seqShift = 2'd1,   // Field rotating, loop active
        seqStop  = 2'd2    // Finishing the rotation after shift drops
    } seqState_t;

    // Inclusive range check on the state count
    function automatic logic inWindow(input stateCount_t value,
                                      input stateCount_t low,
                                      input stateCount_t high);
        return (value >= low) && (value <= high);
    endfunction

endpackage

// ==== rtl/bubbleTiming_macros.svh ====
`ifndef BUBBLE_TIMING_MACROS_SVH
`define BUBBLE_TIMING_MACROS_SVH

// Datapath widths
`define STATE_WIDTH     8
`define POSITION_WIDTH  12

// Minor loop length, positions per loop
`define LOOP_POSITIONS  12'd2053

// Coil-run window, synchronizer delay already folded in
`define COIL_START      8'd18
`define COIL_END        8'd168

// Shift loop: counter wraps LOOP_TOP back to LOOP_RETURN
`define LOOP_TOP        8'd139
`define LOOP_RETURN     8'd20

// Wind-down shortcut, end of -X vector skips to the tail
`define XNEG_END        8'd45
`define STOP_JUMP       8'd166

// Replicator pulses, three counts each
`define REP_PULSE_A     8'd21
`define REP_PULSE_B     8'd141
`define REP_PULSE_LEN   8'd3

// Sense amplifier landmarks
`define CLAMP_START     8'd56   // Detector clamp released
`define STROBE_START    8'd78   // Data strobe opens
`define SENSE_END       8'd93   // Both close after this count

`endif
